//--- id_branch_unit.sv
// branch compare and jump target logic of the decode stage, drives the redirect to fetch
module id_branch_unit (
  input  id_pkg::ctrl_t  i_ctrl,
  input  id_pkg::xword_t i_pc,
  input  id_pkg::xword_t i_rs1_data,
  input  id_pkg::xword_t i_rs2_data,
  output logic           o_taken,
  output id_pkg::xword_t o_target
);

  logic           eq;
  logic           lt;
  logic           ltu;
  logic           cond;
  id_pkg::xword_t jalr_sum;

  assign eq  = (i_rs1_data == i_rs2_data);
  assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_ctrl.br_func)
      3'b000:  cond = eq;    // beq
      3'b001:  cond = !eq;   // bne
      3'b100:  cond = lt;    // blt
      3'b101:  cond = !lt;   // bge
      3'b110:  cond = ltu;   // bltu
      3'b111:  cond = !ltu;  // bgeu
      default: cond = 1'b0;
    endcase
  end

  assign o_taken = i_ctrl.is_jal || i_ctrl.is_jalr || (i_ctrl.is_branch && cond);

  assign jalr_sum = i_rs1_data + i_ctrl.imm;

  // jalr drops bit 0 of the sum
  assign o_target = i_ctrl.is_jalr ? {jalr_sum[id_pkg::XLEN-1:1], 1'b0}
                                   : i_pc + i_ctrl.imm;

endmodule

//--- id_decoder.sv
// combinational RV64I subset decoder, instantiated by the decode stage to build its control bundle
module id_decoder (
  input  id_pkg::inst_t i_inst,
  output id_pkg::ctrl_t o_ctrl
);

  localparam int XL = id_pkg::XLEN;

  logic [6:0]     opcode;
  logic [2:0]     funct3;
  logic [6:0]     funct7;
  logic           bad;
  id_pkg::xword_t imm_i;
  id_pkg::xword_t imm_u;
  id_pkg::xword_t imm_b;
  id_pkg::xword_t imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  // immediates, all sign-extended from bit 31
  assign imm_i = {{(XL-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{(XL-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_b = {{(XL-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_j = {{(XL-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  // shared by op and op-imm, alt selects sub / sra
  function automatic id_pkg::alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  funct_to_alu = alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  funct_to_alu = id_pkg::ALU_SLL;
      3'b010:  funct_to_alu = id_pkg::ALU_SLT;
      3'b011:  funct_to_alu = id_pkg::ALU_SLTU;
      3'b100:  funct_to_alu = id_pkg::ALU_XOR;
      3'b101:  funct_to_alu = alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  funct_to_alu = id_pkg::ALU_OR;
      default: funct_to_alu = id_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    o_ctrl         = '0;
    o_ctrl.rs1     = i_inst[19:15];
    o_ctrl.rs2     = i_inst[24:20];
    o_ctrl.br_func = funct3;
    bad            = 1'b0;
    case (opcode)
      id_pkg::OPC_LUI: begin
        o_ctrl.imm      = imm_u;
        o_ctrl.alu_op   = id_pkg::ALU_PASS2;
        o_ctrl.src2_sel = id_pkg::SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
      end
      id_pkg::OPC_AUIPC: begin
        o_ctrl.imm      = imm_u;
        o_ctrl.src1_sel = id_pkg::SRC1_PC;
        o_ctrl.src2_sel = id_pkg::SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
      end
      id_pkg::OPC_JAL: begin
        o_ctrl.imm      = imm_j;
        o_ctrl.src1_sel = id_pkg::SRC1_PC;  // link = pc + 4
        o_ctrl.src2_sel = id_pkg::SRC2_FOUR;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.is_jal   = 1'b1;
      end
      id_pkg::OPC_JALR: begin
        o_ctrl.imm      = imm_i;
        o_ctrl.rs1_used = 1'b1;
        o_ctrl.src1_sel = id_pkg::SRC1_PC;
        o_ctrl.src2_sel = id_pkg::SRC2_FOUR;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.is_jalr  = 1'b1;
        bad             = (funct3 != 3'b000);
      end
      id_pkg::OPC_BRANCH: begin
        o_ctrl.imm       = imm_b;
        o_ctrl.rs1_used  = 1'b1;
        o_ctrl.rs2_used  = 1'b1;
        o_ctrl.alu_op    = id_pkg::ALU_SUB;
        o_ctrl.is_branch = 1'b1;
        bad              = (funct3 == 3'b010) || (funct3 == 3'b011);
      end
      id_pkg::OPC_OP_IMM: begin
        o_ctrl.imm      = imm_i;
        o_ctrl.rs1_used = 1'b1;
        o_ctrl.src2_sel = id_pkg::SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.alu_op   = funct_to_alu(funct3, (funct3 == 3'b101) && i_inst[30]);
        // rv64 shifts take a 6-bit shamt, the upper six bits select the shift kind
        if (funct3 == 3'b001) begin
          bad = (i_inst[31:26] != 6'b000000);
        end else if (funct3 == 3'b101) begin
          bad = (i_inst[31:26] != 6'b000000) && (i_inst[31:26] != 6'b010000);
        end
      end
      id_pkg::OPC_OP: begin
        o_ctrl.rs1_used = 1'b1;
        o_ctrl.rs2_used = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.alu_op   = funct_to_alu(funct3, funct7[5]);
        if (funct7 == 7'b0100000) begin
          bad = (funct3 != 3'b000) && (funct3 != 3'b101);
        end else begin
          bad = (funct7 != 7'b0000000);
        end
      end
      default: bad = 1'b1;
    endcase

    if (bad) begin  // nothing of an invalid inst may take effect
      o_ctrl.invalid   = 1'b1;
      o_ctrl.gpr_wen   = 1'b0;
      o_ctrl.rs1_used  = 1'b0;
      o_ctrl.rs2_used  = 1'b0;
      o_ctrl.is_branch = 1'b0;
      o_ctrl.is_jal    = 1'b0;
      o_ctrl.is_jalr   = 1'b0;
    end
    // rd zeroed when nothing is written, later stages compare it as is
    o_ctrl.rd = o_ctrl.gpr_wen ? i_inst[11:7] : '0;
  end

endmodule

//--- id_gpr_file.sv
// 32 x 64 general purpose register file for the decode stage, two async reads and a writeback port
module id_gpr_file (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  id_pkg::gpr_addr_t i_raddr1,
  input  id_pkg::gpr_addr_t i_raddr2,
  output id_pkg::xword_t    o_rdata1,
  output id_pkg::xword_t    o_rdata2,
  input  id_pkg::wb_to_rf_t i_wb
);

  id_pkg::xword_t gpr [1:31];  // x0 has no storage

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        gpr[i] <= '0;
      end
    end else if (i_wb.wen && (i_wb.waddr != '0)) begin
      gpr[i_wb.waddr] <= i_wb.wdata;
    end
  end

  // no bypass, a write shows from the next cycle
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : gpr[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : gpr[i_raddr2];

  // a writeback must name one real register
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_wb.wen |-> !$isunknown(i_wb.waddr))
    else $error("gpr: write with an undefined register index");

endmodule

//--- id_hazard_check.sv
// read-after-write interlock of the decode stage against EX, MEM and WB destination registers
module id_hazard_check (
  input  id_pkg::gpr_addr_t i_rs1,
  input  id_pkg::gpr_addr_t i_rs2,
  input  logic              i_rs1_used,
  input  logic              i_rs2_used,
  input  id_pkg::gpr_addr_t i_es_rd,
  input  id_pkg::gpr_addr_t i_ms_rd,
  input  id_pkg::gpr_addr_t i_ws_rd,
  output logic              o_stall
);

  logic rs1_hit;
  logic rs2_hit;

  // x0 never waits, a later stage with no write drives rd = 0
  function automatic logic src_hit(
    input id_pkg::gpr_addr_t src,
    input logic              used,
    input id_pkg::gpr_addr_t es_rd,
    input id_pkg::gpr_addr_t ms_rd,
    input id_pkg::gpr_addr_t ws_rd
  );
    src_hit = used && (src != '0) &&
              ((src == es_rd) || (src == ms_rd) || (src == ws_rd));
  endfunction

  assign rs1_hit = src_hit(i_rs1, i_rs1_used, i_es_rd, i_ms_rd, i_ws_rd);
  assign rs2_hit = src_hit(i_rs2, i_rs2_used, i_es_rd, i_ms_rd, i_ws_rd);
  assign o_stall = rs1_hit || rs2_hit;

endmodule

//--- id_pkg.sv
// shared widths, opcodes, decode enums and stage bus structs for the decode stage and its testbench
package id_pkg;

  localparam int XLEN = 64;

  typedef logic [31:0]     inst_t;
  typedef logic [XLEN-1:0] xword_t;
  typedef logic [4:0]      gpr_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS2  // result is operand 2, used by lui
  } alu_op_e;

  typedef enum logic {
    SRC1_RS1,
    SRC1_PC
  } src1_sel_e;

  typedef enum logic [1:0] {
    SRC2_RS2,
    SRC2_IMM,
    SRC2_FOUR  // link value pc + 4
  } src2_sel_e;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  typedef struct packed {
    inst_t  inst;
    xword_t pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic      wen;
    gpr_addr_t waddr;
    xword_t    wdata;
  } wb_to_rf_t;

  typedef struct packed {
    logic   valid;
    xword_t target;
  } br_bus_t;

  typedef struct packed {
    xword_t    rs1_data;
    xword_t    rs2_data;
    xword_t    imm;
    xword_t    pc;
    alu_op_e   alu_op;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;
    gpr_addr_t rd;
    logic      gpr_wen;
    logic      invalid;
  } ds_to_es_t;

  typedef struct packed {
    gpr_addr_t rs1;
    gpr_addr_t rs2;
    gpr_addr_t rd;
    logic      rs1_used;
    logic      rs2_used;
    xword_t    imm;
    alu_op_e   alu_op;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;
    logic      gpr_wen;
    logic      is_branch;
    logic [2:0] br_func;  // funct3 of the branch
    logic      is_jal;
    logic      is_jalr;
    logic      invalid;
  } ctrl_t;

endpackage

//--- id_stage.sv
// decode stage top: fetch-to-decode register, handshake, operand read, interlock and redirect
module id_stage (
  input  logic              i_clk,
  input  logic              i_rst_n,
  // from fetch
  input  logic              i_fs_valid,
  input  id_pkg::fs_to_ds_t i_fs_bus,
  output logic              o_ds_allowin,
  // to execute
  output logic              o_ds_to_es_valid,
  output id_pkg::ds_to_es_t o_ds_to_es_bus,
  input  logic              i_es_allowin,
  // writeback to register file
  input  id_pkg::wb_to_rf_t i_wb,
  // interlock, destination regs of later stages
  input  id_pkg::gpr_addr_t i_es_rd,
  input  id_pkg::gpr_addr_t i_ms_rd,
  input  id_pkg::gpr_addr_t i_ws_rd,
  // redirect to fetch
  output id_pkg::br_bus_t   o_br_bus
);

  logic              ds_valid;
  id_pkg::fs_to_ds_t ds_bus_r;
  id_pkg::ctrl_t     ctrl;
  id_pkg::xword_t    rs1_data;
  id_pkg::xword_t    rs2_data;
  logic              stall;
  logic              handoff;
  logic              fs_accept;
  logic              br_taken;
  id_pkg::xword_t    br_target;

  assign o_ds_to_es_valid = ds_valid && !stall;
  assign handoff          = o_ds_to_es_valid && i_es_allowin;
  assign o_ds_allowin     = !ds_valid || handoff;
  assign fs_accept        = i_fs_valid && o_ds_allowin && !o_br_bus.valid;  // wrong path dropped

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= fs_accept;
    end
  end

  always_ff @(posedge i_clk) begin
    if (fs_accept) begin
      ds_bus_r <= i_fs_bus;
    end
  end

  id_decoder u_decoder (
    .i_inst (ds_bus_r.inst),
    .o_ctrl (ctrl)
  );

  id_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (ctrl.rs1),
    .i_raddr2 (ctrl.rs2),
    .o_rdata1 (rs1_data),
    .o_rdata2 (rs2_data),
    .i_wb     (i_wb)
  );

  id_hazard_check u_hazard_check (
    .i_rs1      (ctrl.rs1),
    .i_rs2      (ctrl.rs2),
    .i_rs1_used (ctrl.rs1_used),
    .i_rs2_used (ctrl.rs2_used),
    .i_es_rd    (i_es_rd),
    .i_ms_rd    (i_ms_rd),
    .i_ws_rd    (i_ws_rd),
    .o_stall    (stall)
  );

  id_branch_unit u_branch_unit (
    .i_ctrl     (ctrl),
    .i_pc       (ds_bus_r.pc),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_taken    (br_taken),
    .o_target   (br_target)
  );

  // strobe only on the hand-off, no back-pressure from fetch
  assign o_br_bus.valid  = handoff && br_taken;
  assign o_br_bus.target = br_target;

  always_comb begin
    // unused source fields read as zero so the bus ignores unrelated writebacks
    o_ds_to_es_bus.rs1_data = ctrl.rs1_used ? rs1_data : '0;
    o_ds_to_es_bus.rs2_data = ctrl.rs2_used ? rs2_data : '0;
    o_ds_to_es_bus.imm      = ctrl.imm;
    o_ds_to_es_bus.pc       = ds_bus_r.pc;
    o_ds_to_es_bus.alu_op   = ctrl.alu_op;
    o_ds_to_es_bus.src1_sel = ctrl.src1_sel;
    o_ds_to_es_bus.src2_sel = ctrl.src2_sel;
    o_ds_to_es_bus.rd       = ctrl.rd;
    o_ds_to_es_bus.gpr_wen  = ctrl.gpr_wen;
    o_ds_to_es_bus.invalid  = ctrl.invalid;
  end

  // redirect is a one-cycle strobe, the wrong-path offer never fills the entry
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_br_bus.valid |=> !o_br_bus.valid)
    else $error("id_stage: redirect held longer than one cycle");

  // held item must not change while execute refuses it
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_ds_to_es_valid && !i_es_allowin) |=> $stable(o_ds_to_es_bus))
    else $error("id_stage: execute bus changed under back-pressure");

endmodule

//--- list.f
+incdir+.
id_pkg.sv
id_decoder.sv
id_gpr_file.sv
id_hazard_check.sv
id_branch_unit.sv
id_stage.sv
tb_id_stage.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator, then judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_id_stage -f list.f -o tb_id_stage
./obj_dir/tb_id_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
grep -q "TEST OK" sim.log

//--- tb_id_tasks.svh
// instruction encoders and directed decode-stage tests, included inside the testbench top

function automatic id_pkg::inst_t enc_r(input logic [6:0] f7, input id_pkg::gpr_addr_t rs2,
    input id_pkg::gpr_addr_t rs1, input logic [2:0] f3, input id_pkg::gpr_addr_t rd);
  return {f7, rs2, rs1, f3, rd, id_pkg::OPC_OP};
endfunction

function automatic id_pkg::inst_t enc_i(input logic [11:0] imm, input id_pkg::gpr_addr_t rs1,
    input logic [2:0] f3, input id_pkg::gpr_addr_t rd, input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic id_pkg::inst_t enc_u(input logic [19:0] imm, input id_pkg::gpr_addr_t rd,
    input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic id_pkg::inst_t enc_b(input logic [12:0] off, input id_pkg::gpr_addr_t rs2,
    input id_pkg::gpr_addr_t rs1, input logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], id_pkg::OPC_BRANCH};
endfunction

function automatic id_pkg::inst_t enc_j(input logic [20:0] off, input id_pkg::gpr_addr_t rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, id_pkg::OPC_JAL};
endfunction

task automatic test_alu();
  x1_val = rand64();
  x2_val = rand64();
  wb_write(5'd1, x1_val);
  wb_write(5'd2, x2_val);
  issue(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5), 64'h1000, 1'b0);
  check_bus("add", make_exp(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2, '0,
            5'd5, 1'b1, x1_val, x2_val, 64'h1000));
  issue(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd6), 64'h1004, 1'b0);
  check_bus("sub", make_exp(id_pkg::ALU_SUB, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2, '0,
            5'd6, 1'b1, x1_val, x2_val, 64'h1004));
  issue(enc_i(12'hffb, 5'd1, 3'b000, 5'd7, id_pkg::OPC_OP_IMM), 64'h1008, 1'b0);  // -5
  check_bus("addi", make_exp(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_IMM,
            64'hffff_ffff_ffff_fffb, 5'd7, 1'b1, x1_val, '0, 64'h1008));
  issue(enc_u(20'h80001, 5'd8, id_pkg::OPC_LUI), 64'h100c, 1'b0);
  check_bus("lui", make_exp(id_pkg::ALU_PASS2, id_pkg::SRC1_RS1, id_pkg::SRC2_IMM,
            64'hffff_ffff_8000_1000, 5'd8, 1'b1, '0, '0, 64'h100c));
  issue(enc_u(20'h00012, 5'd9, id_pkg::OPC_AUIPC), 64'h1010, 1'b0);
  check_bus("auipc", make_exp(id_pkg::ALU_ADD, id_pkg::SRC1_PC, id_pkg::SRC2_IMM,
            64'h12000, 5'd9, 1'b1, '0, '0, 64'h1010));
endtask

task automatic test_x0();
  wb_write(5'd0, rand64());  // must be dropped
  issue(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd3), 64'h2000, 1'b0);
  check_bus("add x0", make_exp(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2, '0,
            5'd3, 1'b1, '0, '0, 64'h2000));
endtask

task automatic test_interlock();
  @(posedge clk);
  es_rd <= 5'd1;
  send(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd10), 64'h3000, 1'b0);
  repeat (3) begin
    @(negedge clk);
    check(!ds_to_es_valid && !ds_allowin, "rs1 hazard on EX did not stall");
    check(ds_to_es_bus.pc == 64'h3000, "stalled entry was not held");
  end
  @(posedge clk);
  es_rd <= 5'd0;
  @(negedge clk);
  check(ds_to_es_valid, "stall not released after EX rd cleared");
  check_bus("add after stall", make_exp(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2,
            '0, 5'd10, 1'b1, x1_val, x2_val, 64'h3000));
  issue(enc_r(7'h00, 5'd2, 5'd0, 3'b000, 5'd11), 64'h3004, 1'b0);  // x0 against rd 0
  @(posedge clk);
  es_rd <= 5'd5;
  issue(enc_i(12'd5, 5'd1, 3'b000, 5'd12, id_pkg::OPC_OP_IMM), 64'h3008, 1'b0);  // rs2 field 5
  @(posedge clk);
  es_rd <= 5'd0;
  ms_rd <= 5'd2;  // rs2 against MEM, then rs1 against WB
  send(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd14), 64'h300c, 1'b0);
  @(negedge clk);
  check(!ds_to_es_valid && !ds_allowin, "rs2 hazard on MEM did not stall");
  @(posedge clk);
  ms_rd <= 5'd0;
  ws_rd <= 5'd1;
  @(negedge clk);
  check(!ds_to_es_valid && !ds_allowin, "rs1 hazard on WB did not stall");
  @(posedge clk);
  ws_rd <= 5'd0;
  @(negedge clk);
  check(ds_to_es_valid, "stall not released after WB rd cleared");
endtask

task automatic test_backpressure();
  id_pkg::ds_to_es_t held;
  @(posedge clk);
  es_allowin <= 1'b0;
  issue(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd13), 64'h4000, 1'b0);
  held = ds_to_es_bus;
  check_bus("or", make_exp(id_pkg::ALU_OR, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2, '0,
            5'd13, 1'b1, x1_val, x2_val, 64'h4000));
  repeat (4) begin
    @(negedge clk);
    check(ds_to_es_valid && !ds_allowin, "valid or allowin wrong under back-pressure");
    check(ds_to_es_bus == held, "bus changed under back-pressure");
  end
  @(posedge clk);
  es_allowin <= 1'b1;
  @(negedge clk);
  check(ds_to_es_valid && ds_allowin, "no hand-off after EX allowin raised");
  @(negedge clk);
  check(!ds_to_es_valid, "item handed off more than once");
endtask

// hand-off of one control transfer, then the cycle after it
task automatic ctrl_case(input string name, input id_pkg::inst_t inst,
    input id_pkg::ds_to_es_t exp, input logic taken, input id_pkg::xword_t target);
  issue(inst, exp.pc, taken);
  check_bus(name, exp);
  check(br_bus.valid == taken, $sformatf("%s: redirect %b, expected %b", name,
        br_bus.valid, taken));
  if (taken) begin
    check(br_bus.target == target, $sformatf("%s: target %h, expected %h", name,
          br_bus.target, target));
  end
  @(posedge clk);
  fs_valid <= 1'b0;
  @(negedge clk);
  check(!br_bus.valid, $sformatf("%s: redirect longer than one cycle", name));
  check(!ds_to_es_valid, $sformatf("%s: wrong-path instruction reached EX", name));
endtask

task automatic test_ctrl();
  id_pkg::xword_t x4_val;
  id_pkg::xword_t x5_val;
  id_pkg::xword_t x7_val;
  x4_val = rand64() | 64'h8000_0000_0000_0000;  // negative when signed
  x5_val = rand64() >> 1;
  x7_val = rand64() & ~64'd1;  // sum with imm 7 is odd
  wb_write(5'd4, x4_val);
  wb_write(5'd5, x5_val);
  wb_write(5'd7, x7_val);
  ctrl_case("beq", enc_b(13'd16, 5'd1, 5'd1, 3'b000), make_exp(id_pkg::ALU_SUB,
            id_pkg::SRC1_RS1, id_pkg::SRC2_RS2, 64'd16, 5'd0, 1'b0, x1_val, x1_val,
            64'h5000), 1'b1, 64'h5010);
  ctrl_case("bne", enc_b(13'd16, 5'd1, 5'd1, 3'b001), make_exp(id_pkg::ALU_SUB,
            id_pkg::SRC1_RS1, id_pkg::SRC2_RS2, 64'd16, 5'd0, 1'b0, x1_val, x1_val,
            64'h5004), 1'b0, '0);
  ctrl_case("bltu", enc_b(13'h1fe0, 5'd4, 5'd5, 3'b110), make_exp(id_pkg::ALU_SUB,
            id_pkg::SRC1_RS1, id_pkg::SRC2_RS2, 64'hffff_ffff_ffff_ffe0, 5'd0, 1'b0,
            x5_val, x4_val, 64'h5008), x5_val < x4_val, 64'h5008 - 64'd32);
  ctrl_case("blt", enc_b(13'h1fe0, 5'd4, 5'd5, 3'b100), make_exp(id_pkg::ALU_SUB,
            id_pkg::SRC1_RS1, id_pkg::SRC2_RS2, 64'hffff_ffff_ffff_ffe0, 5'd0, 1'b0,
            x5_val, x4_val, 64'h500c), $signed(x5_val) < $signed(x4_val), 64'h500c - 64'd32);
  ctrl_case("jal", enc_j(21'h1ffff0, 5'd1), make_exp(id_pkg::ALU_ADD, id_pkg::SRC1_PC,
            id_pkg::SRC2_FOUR, 64'hffff_ffff_ffff_fff0, 5'd1, 1'b1, '0, '0, 64'h6000),
            1'b1, 64'h6000 - 64'd16);
  ctrl_case("jalr", enc_i(12'd7, 5'd7, 3'b000, 5'd6, id_pkg::OPC_JALR),
            make_exp(id_pkg::ALU_ADD, id_pkg::SRC1_PC, id_pkg::SRC2_FOUR, 64'd7, 5'd6, 1'b1,
            x7_val, '0, 64'h6004), 1'b1, (x7_val + 64'd7) & ~64'd1);
endtask

task automatic test_invalid();
  issue(enc_i(12'd8, 5'd1, 3'b011, 5'd5, 7'b0000011), 64'h7000, 1'b0);  // ld
  check(ds_to_es_bus.invalid, "load opcode not flagged invalid");
  check(!ds_to_es_bus.gpr_wen, "invalid instruction keeps gpr_wen");
  check(ds_to_es_bus.pc == 64'h7000, "invalid instruction lost its pc");
  check(!br_bus.valid, "invalid instruction raised a redirect");
endtask

//--- tb_id_stage.sv
// testbench for the decode stage, drives the DUT through the directed tests in tb_id_tasks.svh
module tb_id_stage;

  localparam int MAX_CYCLES = 2000;  // six tests of under 100 cycles, plus margin

  // addi x31, x0, 1 offered on the wrong path after a taken transfer
  localparam id_pkg::inst_t WRONG_PATH_INST = {12'd1, 5'd0, 3'b000, 5'd31, 7'b0010011};

  logic              clk;
  logic              rst_n;
  logic              fs_valid;
  id_pkg::fs_to_ds_t fs_bus;
  logic              ds_allowin;
  logic              ds_to_es_valid;
  id_pkg::ds_to_es_t ds_to_es_bus;
  logic              es_allowin;
  id_pkg::wb_to_rf_t wb;
  id_pkg::gpr_addr_t es_rd;
  id_pkg::gpr_addr_t ms_rd;
  id_pkg::gpr_addr_t ws_rd;
  id_pkg::br_bus_t   br_bus;
  int                cycles = 0;
  id_pkg::xword_t    x1_val;
  id_pkg::xword_t    x2_val;

  id_stage u_dut (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_fs_valid       (fs_valid),
    .i_fs_bus         (fs_bus),
    .o_ds_allowin     (ds_allowin),
    .o_ds_to_es_valid (ds_to_es_valid),
    .o_ds_to_es_bus   (ds_to_es_bus),
    .i_es_allowin     (es_allowin),
    .i_wb             (wb),
    .i_es_rd          (es_rd),
    .i_ms_rd          (ms_rd),
    .i_ws_rd          (ws_rd),
    .o_br_bus         (br_bus)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic check(input logic ok, input string msg);
    assert (ok) else begin
      $display("ERR %0t %s", $time, msg);
      $display("TEST FAILED");
      $fatal(1, "check failed");
    end
  endtask

  function automatic id_pkg::ds_to_es_t make_exp(input id_pkg::alu_op_e alu,
      input id_pkg::src1_sel_e s1, input id_pkg::src2_sel_e s2, input id_pkg::xword_t imm,
      input id_pkg::gpr_addr_t rd, input logic wen, input id_pkg::xword_t d1,
      input id_pkg::xword_t d2, input id_pkg::xword_t pc);
    return '{rs1_data: d1, rs2_data: d2, imm: imm, pc: pc, alu_op: alu, src1_sel: s1,
             src2_sel: s2, rd: rd, gpr_wen: wen, invalid: 1'b0};
  endfunction

  task automatic check_bus(input string name, input id_pkg::ds_to_es_t exp);
    check(ds_to_es_bus == exp, $sformatf("%s: bus %h, expected %h", name, ds_to_es_bus, exp));
  endtask

  function automatic id_pkg::xword_t rand64();
    return {$urandom(), $urandom()};
  endfunction

  task automatic wb_write(input id_pkg::gpr_addr_t addr, input id_pkg::xword_t data);
    @(posedge clk);
    wb <= '{wen: 1'b1, waddr: addr, wdata: data};
    @(posedge clk);
    wb.wen <= 1'b0;
  endtask

  // returns just after the edge that takes the offer
  task automatic send(input id_pkg::inst_t inst, input id_pkg::xword_t pc,
                      input logic wrong_path);
    @(posedge clk);
    fs_valid <= 1'b1;
    fs_bus   <= '{inst: inst, pc: pc};
    do begin
      @(negedge clk);
    end while (!(ds_allowin && !br_bus.valid));
    @(posedge clk);
    if (wrong_path) begin
      fs_bus <= '{inst: WRONG_PATH_INST, pc: pc + 64'd4};  // fetch runs ahead
    end else begin
      fs_valid <= 1'b0;
    end
  endtask

  task automatic issue(input id_pkg::inst_t inst, input id_pkg::xword_t pc,
                       input logic wrong_path);
    send(inst, pc, wrong_path);
    @(negedge clk);
    check(ds_to_es_valid, $sformatf("pc %h not valid the cycle after acceptance", pc));
  endtask

  `include "tb_id_tasks.svh"

  initial begin
    void'($urandom(32'hb36e3b84));
    rst_n      = 1'b0;
    fs_valid   = 1'b0;
    fs_bus     = '0;
    es_allowin = 1'b1;
    wb         = '0;
    es_rd      = '0;
    ms_rd      = '0;
    ws_rd      = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check(ds_allowin && !ds_to_es_valid && !br_bus.valid, "outputs wrong after reset");
    test_alu();
    test_x0();
    test_interlock();
    test_backpressure();
    test_ctrl();
    test_invalid();
    @(posedge clk);
    $display("TEST OK");
    $finish;
  end

endmodule
